//--- all.f
logic/timer_pkg.sv
logic/tick_gen.sv
logic/panel_control.sv
logic/bcd_time_counter.sv
logic/display_pack.sv
logic/timer_top.sv
verification/timer_tb.sv

//--- Makefile
# Verilator build and run for the BCD timer

VERILATOR ?= verilator
TOP       ?= timer_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= TEST PASS
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail
run: compile
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verification/timer_tb.sv
`timescale 1ns/1ps

module timer_tb
  import timer_pkg::*;
();

  localparam int tb_div = 8;
  localparam int max_secs = 59 * 60 + 59;
  localparam int jump_secs = 2 * 60;
  localparam display_word_t flash_word = 16'h5555;
  localparam int margin_cycles = 200;

  typedef struct {
    int run;
    int cd;
    int fast;
    int slow;
    int rnd;
    int presses;
    int press_len;
    int hold;
    int exp_on;
    display_word_t exp;
    int min_changes;
  } step_t;

  logic clk = 1'b0;
  logic reset, run, count_down, jump_btn, fast_btn, slow_btn;
  display_word_t time_display;
  logic blink;

  step_t steps[$];
  logic [31:0] lfsr;
  int cycle_count = 0;
  int cycle_limit = 0;
  int model_secs = 0;
  logic model_down = 1'b0;
  int pending = 0;
  int changes = 0;
  int fast_changes = 0;
  int slow_changes = 0;
  logic prev_run = 1'b0;
  logic prev_flash = 1'b0;
  logic flash_now;
  display_word_t prev_disp = '0;
  int blink_gap = 0;
  logic blink_gap_ok = 1'b0;
  logic prev_blink = 1'b0;
  logic [1:0] prev_btns = 2'b00;

  timer_top #(.normal_div(tb_div)) dut_i (
    .clk(clk), .reset(reset), .run(run), .count_down(count_down),
    .jump_btn(jump_btn), .fast_btn(fast_btn), .slow_btn(slow_btn),
    .time_display(time_display), .blink(blink)
  );

  always #50 clk = ~clk;

  ////////////////////
  // helpers
  ////////////////////

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_display(input string name, input display_word_t got,
                               input display_word_t exp);
    if (got !== exp)
      stop_on_error($sformatf("CHECK FAILED %s expected 0x%h actual 0x%h", name, exp, got));
  endtask

  task automatic check_blink_pattern(input display_word_t got, input logic blink_level);
    display_word_t exp;
    exp = blink_level ? flash_word : 16'h0000;
    if (got !== exp)
      stop_on_error($sformatf("CHECK FAILED time_display (blink %0b) expected 0x%h actual 0x%h",
                              blink_level, exp, got));
  endtask

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_bits(input int n, output int value);
    value = 0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      value = (value << 1) | int'(lfsr[0]);
    end
  endtask

  // reference model works in whole seconds
  function automatic display_word_t to_word(input int t);
    int m;
    int s;
    m = t / 60;
    s = t % 60;
    return {1'b0, 3'(m / 10), 4'(m % 10), 1'b0, 3'(s / 10), 4'(s % 10)};
  endfunction

  function automatic int step_of(input int t, input logic dn);
    if (dn)
      return (t > 0) ? t - 1 : 0;
    return (t < max_secs) ? t + 1 : max_secs;
  endfunction

  function automatic int jump_of(input int t, input logic dn);
    if (dn)
      return (t < jump_secs) ? 0 : t - jump_secs;
    return (t + jump_secs > max_secs) ? max_secs : t + jump_secs;
  endfunction

  // clk cycles between blink toggles for the {fast, slow} buttons
  function automatic int blink_period(input logic [1:0] btns);
    case (btns)
      2'b10:   return tb_div / 2;
      2'b01:   return 2 * tb_div;
      default: return tb_div;
    endcase
  endfunction

  task automatic add_row(input int r, input int cd, input int f, input int sl, input int rnd,
                         input int np, input int pl, input int hold, input int exp_on,
                         input display_word_t exp, input int min_chg);
    steps.push_back('{r, cd, f, sl, rnd, np, pl, hold, exp_on, exp, min_chg});
  endtask

  ////////////////////
  // monitor
  ////////////////////

  always @(negedge clk)
  begin
    if (!reset)
    begin
      flash_now = fast_btn && slow_btn;
      if (flash_now)
      begin
        check_blink_pattern(time_display, blink);
        if (time_display != prev_disp)
          changes++;
      end
      else if (prev_flash)
        check_display("time_display", time_display, to_word(model_secs));
      else if (time_display != prev_disp)
      begin
        changes++;
        if (pending > 0 && time_display == to_word(jump_of(model_secs, model_down)))
        begin
          model_secs = jump_of(model_secs, model_down);
          pending--;
        end
        else if (prev_run)
        begin
          check_display("time_display", time_display, to_word(step_of(model_secs, model_down)));
          model_secs = step_of(model_secs, model_down);
        end
        else
          check_display("time_display", time_display, to_word(model_secs));
      end
      // blink period follows the speed, restarted by a button change
      blink_gap++;
      if (blink !== prev_blink)
      begin
        if (blink_gap_ok && blink_gap != blink_period(prev_btns))
          stop_on_error($sformatf("blink toggled after %0d cycles where %0d were expected",
                                  blink_gap, blink_period(prev_btns)));
        blink_gap_ok = 1'b1;
        blink_gap = 0;
      end
      if ({fast_btn, slow_btn} != prev_btns)
        blink_gap_ok = 1'b0;
      // direction register follows the switch while paused
      if (!run)
        model_down = count_down;
      prev_run = run;
      prev_flash = flash_now;
      prev_disp = time_display;
      prev_blink = blink;
      prev_btns = {fast_btn, slow_btn};
    end
  end

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count > cycle_limit)
      stop_on_error($sformatf("timeout after %0d cycles, the sequence did not finish",
                              cycle_count));
  end

  ////////////////////
  // stimulus
  ////////////////////

  task automatic apply_step(input int idx);
    step_t s;
    s = steps[idx];
    changes = 0;
    run <= (s.run != 0);
    count_down <= (s.cd != 0);
    fast_btn <= (s.fast != 0);
    slow_btn <= (s.slow != 0);
    for (int p = 0; p < s.presses; p++)
    begin
      jump_btn <= 1'b1;
      pending++;
      repeat (s.press_len) @(posedge clk);
      jump_btn <= 1'b0;
      repeat (3) @(posedge clk);
    end
    repeat (s.hold) @(posedge clk);
    // display as seen by the monitor on the last falling edge
    if (s.exp_on != 0)
      check_display("time_display", prev_disp, s.exp);
    if (changes < s.min_changes)
      stop_on_error($sformatf("step %0d made %0d display changes, expected at least %0d",
                              idx, changes, s.min_changes));
    if (s.fast != 0 && s.slow == 0)
      fast_changes += changes;
    else if (s.slow != 0 && s.fast == 0)
      slow_changes += changes;
    pending = 0;
  endtask

  initial
  begin
    step_t s;
    int extra;
    reset = 1'b1;
    run = 1'b0;
    count_down = 1'b0;
    jump_btn = 1'b0;
    fast_btn = 1'b0;
    slow_btn = 1'b0;
    lfsr = 32'he3ddc8d7;
    // run down fast slow rnd presses press_len hold exp_on exp min_changes
    add_row(1, 0, 0, 0, 0,  0,  0, 520, 0, 16'h0000, 60);
    add_row(0, 1, 0, 0, 0,  0,  0,   4, 0, 16'h0000,  0);
    add_row(1, 1, 0, 0, 0,  0,  0, 600, 1, 16'h0000, 60);
    add_row(0, 0, 0, 0, 0,  0,  0,   4, 0, 16'h0000,  0);
    add_row(1, 0, 0, 0, 1,  0,  0, 100, 0, 16'h0000, 10);
    add_row(1, 1, 0, 0, 0,  0,  0, 100, 0, 16'h0000, 10);
    add_row(0, 1, 0, 0, 0,  0,  0,   4, 0, 16'h0000,  0);
    add_row(1, 1, 0, 0, 0,  0,  0,  80, 0, 16'h0000,  8);
    add_row(0, 0, 0, 0, 0,  0,  0,   4, 0, 16'h0000,  0);
    add_row(0, 0, 0, 0, 0,  1, 40,   4, 0, 16'h0000,  1);
    add_row(0, 0, 0, 0, 0, 30,  2,   4, 1, 16'h5959, 28);
    add_row(1, 0, 0, 0, 0,  0,  0,  40, 1, 16'h5959,  0);
    add_row(0, 1, 0, 0, 0,  0,  0,   4, 0, 16'h0000,  0);
    add_row(0, 1, 0, 0, 0, 30,  2,   4, 1, 16'h0000, 30);
    add_row(0, 0, 0, 0, 0,  0,  0,   4, 0, 16'h0000,  0);
    add_row(0, 0, 0, 0, 0,  1,  2,   4, 1, 16'h0200,  1);
    add_row(1, 0, 0, 0, 1,  0,  0,  30, 0, 16'h0000,  2);
    add_row(1, 0, 1, 1, 0,  0,  0, 100, 0, 16'h0000, 10);
    add_row(1, 0, 0, 0, 1,  0,  0,  40, 0, 16'h0000,  3);
    add_row(1, 0, 1, 0, 0,  0,  0, 200, 0, 16'h0000, 40);
    add_row(1, 0, 0, 1, 0,  0,  0, 200, 0, 16'h0000, 10);
    // random hold extensions and the cycle budget
    foreach (steps[i])
    begin
      s = steps[i];
      if (s.rnd != 0)
      begin
        random_bits(5, extra);
        s.hold = s.hold + extra;
        steps[i] = s;
      end
      cycle_limit += s.presses * (s.press_len + 3) + s.hold;
    end
    cycle_limit += margin_cycles;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    foreach (steps[i])
      apply_step(i);
    if (fast_changes <= slow_changes)
      stop_on_error($sformatf("fast speed made %0d changes but slow speed made %0d",
                              fast_changes, slow_changes));
    else
    begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

//--- logic/timer_top.sv
`timescale 1ns/1ps

module timer_top
  import timer_pkg::*;
#(
  parameter int normal_div = 50_000_000
)
(
  input  logic          clk,
  input  logic          reset,
  input  logic          run,
  input  logic          count_down,
  input  logic          jump_btn,
  input  logic          fast_btn,
  input  logic          slow_btn,
  output display_word_t time_display,
  output logic          blink
);

  speed_e     speed;
  logic       count_en;
  logic       down;
  logic       jump;
  logic       tick;
  bcd_digit_t sec_ones;
  bcd_tens_t  sec_tens;
  bcd_digit_t min_ones;
  bcd_tens_t  min_tens;

  ////////////////////
  // buttons and tick
  ////////////////////

  panel_control panel_i (
    .clk(clk), .reset(reset), .run(run), .count_down(count_down),
    .jump_btn(jump_btn), .fast_btn(fast_btn), .slow_btn(slow_btn),
    .speed(speed), .count_en(count_en), .down(down), .jump(jump)
  );

  tick_gen #(.normal_div(normal_div)) tick_i (
    .clk(clk), .reset(reset), .speed(speed), .tick(tick), .blink(blink)
  );

  ////////////////////
  // time and display
  ////////////////////

  bcd_time_counter counter_i (
    .clk(clk), .reset(reset), .tick(tick), .count_en(count_en), .down(down),
    .jump(jump), .sec_ones(sec_ones), .sec_tens(sec_tens),
    .min_ones(min_ones), .min_tens(min_tens)
  );

  display_pack display_i (
    .sec_ones(sec_ones), .sec_tens(sec_tens), .min_ones(min_ones),
    .min_tens(min_tens), .flash(speed == speed_flash), .blink(blink),
    .time_display(time_display)
  );

endmodule

//--- logic/display_pack.sv
`timescale 1ns/1ps

module display_pack
  import timer_pkg::*;
(
  input  bcd_digit_t    sec_ones,
  input  bcd_tens_t     sec_tens,
  input  bcd_digit_t    min_ones,
  input  bcd_tens_t     min_tens,
  input  logic          flash,
  input  logic          blink,
  output display_word_t time_display
);

  display_word_t time_word;

  // bits 7 and 15 stay zero
  assign time_word = {1'b0, min_tens, min_ones, 1'b0, sec_tens, sec_ones};

  ////////////////////
  // output select
  ////////////////////

  always_comb
  begin
    if (flash)
    begin
      // pattern follows the blink level
      if (blink)
        time_display = flash_pattern;
      else
        time_display = '0;
    end
    else
    begin
      time_display = time_word;
    end
  end

endmodule

//--- logic/bcd_time_counter.sv
`timescale 1ns/1ps

module bcd_time_counter
  import timer_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       tick,
  input  logic       count_en,
  input  logic       down,
  input  logic       jump,
  output bcd_digit_t sec_ones,
  output bcd_tens_t  sec_tens,
  output bcd_digit_t min_ones,
  output bcd_tens_t  min_tens
);

  localparam int max_minutes = max_min_tens * 10 + max_min_ones;

  bcd_digit_t so_n;
  bcd_tens_t  st_n;
  bcd_digit_t mo_n;
  bcd_tens_t  mt_n;
  logic [6:0] min_bin;
  logic [6:0] min_up;
  logic [6:0] min_dn;
  logic       at_max;
  logic       at_min;

  assign at_max = (min_tens == max_min_tens) && (min_ones == max_min_ones) &&
                  (sec_tens == max_sec_tens) && (sec_ones == max_sec_ones);
  assign at_min = (min_tens == '0) && (min_ones == '0) &&
                  (sec_tens == '0) && (sec_ones == '0);

  // minutes in binary for the jump arithmetic
  assign min_bin = 7'(min_tens) * 7'd10 + 7'(min_ones);
  assign min_up  = min_bin + 7'(jump_minutes);
  assign min_dn  = min_bin - 7'(jump_minutes);

  ////////////////////
  // next time value
  ////////////////////

  always_comb
  begin
    so_n = sec_ones;
    st_n = sec_tens;
    mo_n = min_ones;
    mt_n = min_tens;
    // jump beats a tick in the same cycle
    if (jump)
    begin
      if (!down && (min_up > 7'(max_minutes)))
      begin
        so_n = max_sec_ones;
        st_n = max_sec_tens;
        mo_n = max_min_ones;
        mt_n = max_min_tens;
      end
      else if (down && (min_bin < 7'(jump_minutes)))
      begin
        so_n = '0;
        st_n = '0;
        mo_n = '0;
        mt_n = '0;
      end
      else if (!down)
      begin
        mt_n = 3'(min_up / 7'd10);
        mo_n = 4'(min_up % 7'd10);
      end
      else
      begin
        mt_n = 3'(min_dn / 7'd10);
        mo_n = 4'(min_dn % 7'd10);
      end
    end
    else if (tick && count_en && !down && !at_max)
    begin
      // count up, carry ripples through the digits
      so_n = (sec_ones == 4'd9) ? 4'd0 : sec_ones + 1'b1;
      if (sec_ones == 4'd9)
        st_n = (sec_tens == 3'd5) ? 3'd0 : sec_tens + 1'b1;
      if (sec_ones == 4'd9 && sec_tens == 3'd5)
        mo_n = (min_ones == 4'd9) ? 4'd0 : min_ones + 1'b1;
      if (sec_ones == 4'd9 && sec_tens == 3'd5 && min_ones == 4'd9)
        mt_n = min_tens + 1'b1;
    end
    else if (tick && count_en && down && !at_min)
    begin
      // count down, borrow ripples the same way
      so_n = (sec_ones == 4'd0) ? 4'd9 : sec_ones - 1'b1;
      if (sec_ones == 4'd0)
        st_n = (sec_tens == 3'd0) ? 3'd5 : sec_tens - 1'b1;
      if (sec_ones == 4'd0 && sec_tens == 3'd0)
        mo_n = (min_ones == 4'd0) ? 4'd9 : min_ones - 1'b1;
      if (sec_ones == 4'd0 && sec_tens == 3'd0 && min_ones == 4'd0)
        mt_n = min_tens - 1'b1;
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      sec_ones <= '0;
      sec_tens <= '0;
      min_ones <= '0;
      min_tens <= '0;
    end
    else
    begin
      sec_ones <= so_n;
      sec_tens <= st_n;
      min_ones <= mo_n;
      min_tens <= mt_n;
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    (sec_ones <= 4'd9) && (min_ones <= 4'd9) && (sec_tens <= 3'd5) && (min_tens <= 3'd5));

endmodule

//--- logic/panel_control.sv
`timescale 1ns/1ps

module panel_control
  import timer_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   run,
  input  logic   count_down,
  input  logic   jump_btn,
  input  logic   fast_btn,
  input  logic   slow_btn,
  output speed_e speed,
  output logic   count_en,
  output logic   down,
  output logic   jump
);

  logic jump_btn_q;

  ////////////////////
  // speed decode
  ////////////////////

  always_comb
  begin
    case ({fast_btn, slow_btn})
      2'b11:   speed = speed_flash;
      2'b10:   speed = speed_fast;
      2'b01:   speed = speed_slow;
      default: speed = speed_normal;
    endcase
  end

  // flash mode holds the count
  assign count_en = run && (speed != speed_flash);

  ////////////////////
  // button registers
  ////////////////////

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      jump_btn_q <= 1'b0;
      jump       <= 1'b0;
      down       <= 1'b0;
    end
    else
    begin
      jump_btn_q <= jump_btn;
      // one pulse per press, holding does not repeat
      jump <= jump_btn && !jump_btn_q;
      // direction only follows the switch while paused
      if (!run)
        down <= count_down;
    end
  end

  assert property (@(posedge clk) disable iff (reset) jump |=> !jump);

endmodule

//--- logic/tick_gen.sv
`timescale 1ns/1ps

module tick_gen
  import timer_pkg::*;
#(
  parameter int normal_div = 50_000_000
)
(
  input  logic   clk,
  input  logic   reset,
  input  speed_e speed,
  output logic   tick,
  output logic   blink
);

  localparam int slow_div = 2 * normal_div;
  // fast period never drops below two cycles
  localparam int fast_div = (normal_div / 2 < 2) ? 2 : normal_div / 2;
  localparam int cnt_w = $clog2(slow_div + 1);

  logic [cnt_w-1:0] count;
  logic [cnt_w-1:0] last_count;
  speed_e           speed_q;
  logic             speed_changed;

  // terminal count for the selected speed
  always_comb
  begin
    case (speed)
      speed_slow: last_count = cnt_w'(slow_div - 1);
      speed_fast: last_count = cnt_w'(fast_div - 1);
      default:    last_count = cnt_w'(normal_div - 1);
    endcase
  end

  assign speed_changed = (speed != speed_q);
  assign tick = (count == last_count) && !speed_changed;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      count   <= '0;
      speed_q <= speed_normal;
      blink   <= 1'b0;
    end
    else
    begin
      speed_q <= speed;
      // new speed starts a fresh period
      if (speed_changed || tick)
        count <= '0;
      else
        count <= count + 1'b1;
      if (tick)
        blink <= ~blink;
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    (normal_div > 2) && tick |=> !tick);

endmodule

//--- logic/timer_pkg.sv
package timer_pkg;

  ////////////////////
  // digit and display types
  ////////////////////

  // ones digits, 0 to 9
  typedef logic [3:0] bcd_digit_t;

  // tens digits, 0 to 5
  typedef logic [2:0] bcd_tens_t;

  // packed word {0, mm tens, mm ones, 0, ss tens, ss ones}
  typedef logic [15:0] display_word_t;

  // tick speed, flash also freezes the count
  typedef enum logic [1:0] {
    speed_normal,
    speed_slow,
    speed_fast,
    speed_flash
  } speed_e;

  ////////////////////
  // constants
  ////////////////////

  // blinking pattern in flash mode
  localparam display_word_t flash_pattern = 16'h5555;

  // upper limit 59:59
  localparam bcd_tens_t  max_min_tens = 3'd5;
  localparam bcd_digit_t max_min_ones = 4'd9;
  localparam bcd_tens_t  max_sec_tens = 3'd5;
  localparam bcd_digit_t max_sec_ones = 4'd9;

  // minutes added or removed per button press
  localparam int jump_minutes = 2;

endpackage
